/* include/secp_settings.svh */
`ifndef SECP_SETTINGS_SVH
`define SECP_SETTINGS_SVH

// Width of one command or reply stream word
`define SECP_WORD_W 64

// Scalars mod n
`define SECP_SCALAR_W 256

// Words held by the command register file
`define SECP_REG_DEPTH 16

// Command code of VERIFY_SIG
`define SECP_CMD_VERIFY 16'h0201

`define SECP_RPL_WORDS 10

`endif

/* rtl/secp_field_pkg.sv */
`include "secp_settings.svh"

package secp_field_pkg;

  typedef logic [`SECP_SCALAR_W-1:0] scalar_t;

  // secp256k1 group order
  localparam scalar_t CURVE_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  // Signature inputs, s in the low bits as it arrives first
  typedef struct packed {
    scalar_t hash;
    scalar_t r;
    scalar_t s;
  } sig_operands_t;

  typedef struct packed {
    scalar_t u2;
    scalar_t u1;
  } sig_results_t;

endpackage

/* rtl/secp_cmd_pkg.sv */
`include "secp_settings.svh"

package secp_cmd_pkg;
  import secp_field_pkg::*;

  typedef logic [`SECP_WORD_W-1:0] word_t;

  typedef logic [$clog2(`SECP_REG_DEPTH)-1:0] reg_addr_t;

  typedef struct packed {
    word_t dat;
    logic  sop;
    logic  eop;
  } stream_beat_t;

  // First word of every command
  typedef struct packed {
    logic [31:0] rsvd;
    logic [15:0] tag;
    logic [15:0] code;
  } cmd_header_t;

  typedef struct packed {
    logic [5:0] rsvd;
    logic       out_of_range_r;
    logic       out_of_range_s;
  } ver_flags_t;

  // Header goes out first, so it sits in the low word
  typedef struct packed {
    scalar_t u2;
    scalar_t u1;
    word_t   index;
    word_t   header;
  } reply_t;

  // Word addresses of the stored command
  localparam reg_addr_t ADDR_HEADER = 4'd0;
  localparam reg_addr_t ADDR_INDEX  = 4'd1;
  localparam reg_addr_t ADDR_S      = 4'd2;
  localparam reg_addr_t ADDR_R      = 4'd6;
  localparam reg_addr_t ADDR_HASH   = 4'd10;

endpackage

/* rtl/cmd_parser.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module cmd_parser
  import secp_field_pkg::*;
  import secp_cmd_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst,
  input  stream_beat_t  i_cmd_beat,
  input  logic          i_cmd_val,
  output logic          o_cmd_rdy,
  input  logic          i_reply_idle,
  output logic          o_wr_en,
  output reg_addr_t     o_wr_addr,
  output word_t         o_wr_dat,
  output cmd_header_t   o_hdr,
  output word_t         o_index,
  output sig_operands_t o_ops,
  output logic          o_start
);

  // s, r and hash words after the index
  localparam logic [3:0] PARSE_LAST = 4'(3 * `SECP_SCALAR_W / `SECP_WORD_W - 1);

  typedef enum logic [2:0] {S_IDLE, S_INDEX, S_PARSE, S_IGNORE, S_WAIT_REPLY} state_t;

  state_t      state;
  logic [3:0]  cnt;
  logic        reply_seen;
  logic        take;
  cmd_header_t hdr_in;

  assign take   = i_cmd_val && o_cmd_rdy;
  assign hdr_in = i_cmd_beat.dat;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state      <= S_IDLE;
      o_cmd_rdy  <= 1'b0;
      o_wr_en    <= 1'b0;
      o_start    <= 1'b0;
      cnt        <= '0;
      reply_seen <= 1'b0;
    end else begin
      o_wr_en <= 1'b0;
      o_start <= 1'b0;
      case (state)
        S_IDLE: begin
          o_cmd_rdy <= 1'b1;
          cnt       <= '0;
          if (take) begin
            if (hdr_in.code == `SECP_CMD_VERIFY) begin
              o_wr_en <= 1'b1;
              state   <= S_INDEX;
            end else if (!i_cmd_beat.eop) begin
              state <= S_IGNORE;
            end
          end
        end
        S_INDEX: begin
          if (take) begin
            o_wr_en <= 1'b1;
            state   <= S_PARSE;
          end
        end
        S_PARSE: begin
          if (take) begin
            o_wr_en <= 1'b1;
            cnt     <= cnt + 4'd1;
            if (cnt == PARSE_LAST) begin
              // One command in flight, hold off the sender until the reply is out
              o_cmd_rdy  <= 1'b0;
              o_start    <= 1'b1;
              reply_seen <= 1'b0;
              state      <= S_WAIT_REPLY;
            end
          end
        end
        S_IGNORE: begin
          if (take && i_cmd_beat.eop) begin
            state <= S_IDLE;
          end
        end
        S_WAIT_REPLY: begin
          if (!i_reply_idle) begin
            reply_seen <= 1'b1;
          end
          if (reply_seen && i_reply_idle) begin
            o_cmd_rdy <= 1'b1;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Register file write data and operand assembly
  always_ff @(posedge i_clk) begin
    if (take) begin
      o_wr_dat <= i_cmd_beat.dat;
      case (state)
        S_IDLE: begin
          o_wr_addr <= ADDR_HEADER;
          o_hdr     <= hdr_in;
        end
        S_INDEX: begin
          o_wr_addr <= ADDR_INDEX;
          o_index   <= i_cmd_beat.dat;
        end
        S_PARSE: begin
          // s, r and hash are stored back to back from ADDR_S
          o_wr_addr <= ADDR_S + cnt;
          o_ops[cnt*`SECP_WORD_W +: `SECP_WORD_W] <= i_cmd_beat.dat;
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/sig_register_file.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module sig_register_file
  import secp_cmd_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_wr_en,
  input  reg_addr_t i_wr_addr,
  input  word_t     i_wr_dat,
  input  logic      i_dbg_rd,
  input  reg_addr_t i_dbg_addr,
  output word_t     o_dbg_dat,
  output logic      o_dbg_val = 1'b0
);

  word_t mem [`SECP_REG_DEPTH];
  word_t rd_q;
  // Read-valid pipeline, one bit per read in flight
  logic  rd_d1 = 1'b0;

  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_dat;
    end
  end

  // Memory output register then output register
  always_ff @(posedge i_clk) begin
    rd_q      <= mem[i_dbg_addr];
    o_dbg_dat <= rd_q;
  end

  always_ff @(posedge i_clk) begin
    rd_d1     <= i_dbg_rd;
    o_dbg_val <= rd_d1;
  end

  a_dbg_latency: assert property (@(posedge i_clk) i_dbg_rd |-> ##2 o_dbg_val);

endmodule

/* rtl/mod_inverse.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module mod_inverse
  import secp_field_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  scalar_t i_dat,
  input  logic    i_val,
  output logic    o_rdy,
  output scalar_t o_dat,
  output logic    o_val
);

  localparam int W = `SECP_SCALAR_W;
  localparam scalar_t ONE = scalar_t'(1);

  scalar_t    u, v, x1, x2;
  scalar_t    x1_half, x2_half, x1_sub, x2_sub;
  logic [W:0] x1_sum, x2_sum;
  logic       busy;
  logic       finish;

  assign o_rdy  = ~busy;
  assign finish = busy && (u == ONE || v == ONE);

  always_comb begin
    // x/2 mod n, odd values get n added first
    x1_sum  = x1[0] ? {1'b0, x1} + {1'b0, CURVE_N} : {1'b0, x1};
    x2_sum  = x2[0] ? {1'b0, x2} + {1'b0, CURVE_N} : {1'b0, x2};
    x1_half = x1_sum[W:1];
    x2_half = x2_sum[W:1];
    // Differences mod n, adding n back on underflow
    x1_sub  = (x1 >= x2) ? x1 - x2 : x1 - x2 + CURVE_N;
    x2_sub  = (x2 >= x1) ? x2 - x1 : x2 - x1 + CURVE_N;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      o_val <= 1'b0;
    end else begin
      o_val <= 1'b0;
      if (!busy && i_val) begin
        busy <= 1'b1;
      end else if (finish) begin
        busy  <= 1'b0;
        o_val <= 1'b1;
      end
    end
  end

  // One Euclid step per cycle, halving takes priority over subtraction
  always_ff @(posedge i_clk) begin
    if (!busy) begin
      if (i_val) begin
        u  <= i_dat;
        v  <= CURVE_N;
        x1 <= ONE;
        x2 <= '0;
      end
    end else if (u == ONE) begin
      o_dat <= x1;
    end else if (v == ONE) begin
      o_dat <= x2;
    end else if (!u[0]) begin
      u  <= u >> 1;
      x1 <= x1_half;
    end else if (!v[0]) begin
      v  <= v >> 1;
      x2 <= x2_half;
    end else if (u >= v) begin
      u  <= u - v;
      x1 <= x1_sub;
    end else begin
      v  <= v - u;
      x2 <= x2_sub;
    end
  end

  // Zero has no inverse, the engine filters it out with the range check
  a_nonzero_in: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy) |-> (i_dat != '0));

endmodule

/* rtl/mod_mult.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module mod_mult
  import secp_field_pkg::*;
(
  input  logic    i_clk,
  input  logic    i_rst,
  input  scalar_t i_a,
  input  scalar_t i_b,
  input  logic    i_val,
  output logic    o_rdy,
  output scalar_t o_dat,
  output logic    o_val
);

  localparam int W = `SECP_SCALAR_W;
  // Step 0 reduces b, steps 1..W scan a, the last step drives the result
  localparam logic [8:0] LAST_STEP = 9'(W + 1);
  localparam logic [W:0] N_EXT = {1'b0, CURVE_N};

  scalar_t    a_sh, b_red, acc, acc_dbl, acc_next;
  logic [W:0] dbl, dbl_sub, add, add_sub;
  logic [8:0] step;
  logic       busy;

  assign o_rdy = ~busy;

  // Top bit of each difference is the borrow, since both sums stay below 2n
  always_comb begin
    dbl      = {acc, 1'b0};
    dbl_sub  = dbl - N_EXT;
    acc_dbl  = dbl_sub[W] ? dbl[W-1:0] : dbl_sub[W-1:0];
    add      = {1'b0, acc_dbl} + {1'b0, b_red};
    add_sub  = add - N_EXT;
    acc_next = acc_dbl;
    if (a_sh[W-1]) begin
      acc_next = add_sub[W] ? add[W-1:0] : add_sub[W-1:0];
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy  <= 1'b0;
      o_val <= 1'b0;
      step  <= '0;
    end else begin
      o_val <= 1'b0;
      if (!busy) begin
        if (i_val) begin
          busy <= 1'b1;
          step <= '0;
        end
      end else begin
        step <= step + 9'd1;
        if (step == LAST_STEP) begin
          busy  <= 1'b0;
          o_val <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!busy) begin
      if (i_val) begin
        a_sh  <= i_a;
        b_red <= i_b;
        acc   <= '0;
      end
    end else if (step == '0) begin
      b_red <= (b_red >= CURVE_N) ? b_red - CURVE_N : b_red;
    end else if (step == LAST_STEP) begin
      o_dat <= acc;
    end else begin
      acc  <= acc_next;
      a_sh <= a_sh << 1;
    end
  end

  // Fixed latency, busy for the whole run
  a_fixed_latency: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy) |=> (!o_rdy) [*258] ##1 o_val);

endmodule

/* rtl/verify_engine.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module verify_engine
  import secp_field_pkg::*;
  import secp_cmd_pkg::*;
(
  input  logic          i_clk,
  input  logic          i_rst,
  input  logic          i_start,
  input  sig_operands_t i_ops,
  input  cmd_header_t   i_hdr,
  input  word_t         i_index,
  output reply_t        o_reply,
  output logic          o_done
);

  typedef enum logic [1:0] {S_IDLE, S_INV, S_MUL_U1, S_MUL_U2} state_t;

  state_t       state;
  ver_flags_t   flags;
  sig_results_t res;
  scalar_t      w;
  logic         s_bad, r_bad;
  logic         inv_val, inv_rdy, inv_out_val;
  scalar_t      inv_dat;
  logic         mul_val, mul_rdy, mul_out_val;
  scalar_t      mul_a, mul_dat;

  assign s_bad = (i_ops.s == '0) || (i_ops.s >= CURVE_N);
  assign r_bad = (i_ops.r == '0) || (i_ops.r >= CURVE_N);

  // The parser holds its operands until the reply has left
  assign mul_a = (state == S_MUL_U1) ? i_ops.hash : i_ops.r;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state   <= S_IDLE;
      inv_val <= 1'b0;
      mul_val <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (inv_val && inv_rdy) begin
        inv_val <= 1'b0;
      end
      if (mul_val && mul_rdy) begin
        mul_val <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          if (i_start) begin
            if (s_bad) begin
              o_done <= 1'b1;
            end else begin
              inv_val <= 1'b1;
              state   <= S_INV;
            end
          end
        end
        S_INV: begin
          if (inv_out_val) begin
            mul_val <= 1'b1;
            state   <= S_MUL_U1;
          end
        end
        S_MUL_U1: begin
          if (mul_out_val) begin
            mul_val <= 1'b1;
            state   <= S_MUL_U2;
          end
        end
        S_MUL_U2: begin
          if (mul_out_val) begin
            o_done <= 1'b1;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && i_start) begin
      flags                <= '0;
      flags.out_of_range_s <= s_bad;
      flags.out_of_range_r <= r_bad;
      res                  <= '0;
    end
    if (inv_out_val) begin
      w <= inv_dat;
    end
    if (mul_out_val) begin
      if (state == S_MUL_U1) begin
        res.u1 <= mul_dat;
      end else begin
        res.u2 <= mul_dat;
      end
    end
  end

  // Flags replace header bits 39:32
  always_comb begin
    o_reply.header = {i_hdr.rsvd[`SECP_WORD_W/2-1:8], flags, i_hdr.tag, i_hdr.code};
    o_reply.index  = i_index;
    o_reply.u1     = res.u1;
    o_reply.u2     = res.u2;
  end

  mod_inverse u_inv (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_dat (i_ops.s),
    .i_val (inv_val),
    .o_rdy (inv_rdy),
    .o_dat (inv_dat),
    .o_val (inv_out_val)
  );

  mod_mult u_mult (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_a   (mul_a),
    .i_b   (w),
    .i_val (mul_val),
    .o_rdy (mul_rdy),
    .o_dat (mul_dat),
    .o_val (mul_out_val)
  );

endmodule

/* rtl/reply_builder.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module reply_builder
  import secp_cmd_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  reply_t       i_reply,
  input  logic         i_done,
  output stream_beat_t o_rpl_beat,
  output logic         o_rpl_val,
  input  logic         i_rpl_rdy,
  output logic         o_idle
);

  localparam int CNT_W = $clog2(`SECP_RPL_WORDS);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`SECP_RPL_WORDS - 1);

  reply_t           sh;
  logic [CNT_W-1:0] cnt;
  logic             take;

  assign take = o_rpl_val && i_rpl_rdy;

  // Current word is always the low word of the shift register
  assign o_rpl_beat.dat = sh[`SECP_WORD_W-1:0];
  assign o_rpl_beat.sop = (cnt == '0);
  assign o_rpl_beat.eop = (cnt == LAST_WORD);
  assign o_idle         = ~o_rpl_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rpl_val <= 1'b0;
      cnt       <= '0;
    end else if (i_done) begin
      o_rpl_val <= 1'b1;
      cnt       <= '0;
    end else if (take) begin
      if (cnt == LAST_WORD) begin
        o_rpl_val <= 1'b0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_done) begin
      sh <= i_reply;
    end else if (take) begin
      sh <= sh >> `SECP_WORD_W;
    end
  end

  a_hold_beat: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_rpl_val && !i_rpl_rdy) |=> (o_rpl_val && $stable(o_rpl_beat)));

endmodule

/* rtl/secp256k1_verify_top.sv */
`timescale 1ns/100ps

module secp256k1_verify_top
  import secp_field_pkg::*;
  import secp_cmd_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_rst,
  input  stream_beat_t i_cmd_beat,
  input  logic         i_cmd_val,
  output logic         o_cmd_rdy,
  output stream_beat_t o_rpl_beat,
  output logic         o_rpl_val,
  input  logic         i_rpl_rdy,
  input  logic         i_dbg_rd,
  input  reg_addr_t    i_dbg_addr,
  output word_t        o_dbg_dat,
  output logic         o_dbg_val
);

  sig_operands_t ops;
  cmd_header_t   hdr;
  word_t         index;
  logic          start;
  reply_t        reply;
  logic          done;
  logic          reply_idle;
  logic          wr_en;
  reg_addr_t     wr_addr;
  word_t         wr_dat;

  cmd_parser u_parser (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_cmd_beat   (i_cmd_beat),
    .i_cmd_val    (i_cmd_val),
    .o_cmd_rdy    (o_cmd_rdy),
    .i_reply_idle (reply_idle),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_dat     (wr_dat),
    .o_hdr        (hdr),
    .o_index      (index),
    .o_ops        (ops),
    .o_start      (start)
  );

  sig_register_file u_regs (
    .i_clk      (i_clk),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_dat   (wr_dat),
    .i_dbg_rd   (i_dbg_rd),
    .i_dbg_addr (i_dbg_addr),
    .o_dbg_dat  (o_dbg_dat),
    .o_dbg_val  (o_dbg_val)
  );

  verify_engine u_engine (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (start),
    .i_ops   (ops),
    .i_hdr   (hdr),
    .i_index (index),
    .o_reply (reply),
    .o_done  (done)
  );

  reply_builder u_reply (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_reply    (reply),
    .i_done     (done),
    .o_rpl_beat (o_rpl_beat),
    .o_rpl_val  (o_rpl_val),
    .i_rpl_rdy  (i_rpl_rdy),
    .o_idle     (reply_idle)
  );

endmodule

/* verif/tb_secp256k1_verify.sv */
`timescale 1ns/100ps
`include "secp_settings.svh"

module tb_secp256k1_verify
  import secp_field_pkg::*;
  import secp_cmd_pkg::*;
();

  // Up to 20 commands at no more than 1700 cycles each, plus margin
  localparam int CMD_LIMIT      = 20;
  localparam int CYCLES_PER_CMD = 1700;
  localparam int TIMEOUT_CYCLES = CMD_LIMIT * CYCLES_PER_CMD + 6000;
  localparam int CMD_WORDS      = 14;
  localparam word_t FLAG_MASK   = 64'h0000_00FF_0000_0000;

  logic         i_clk;
  logic         i_rst;
  stream_beat_t i_cmd_beat;
  logic         i_cmd_val;
  logic         o_cmd_rdy;
  stream_beat_t o_rpl_beat;
  logic         o_rpl_val;
  logic         i_rpl_rdy;
  logic         i_dbg_rd;
  reg_addr_t    i_dbg_addr;
  word_t        o_dbg_dat;
  logic         o_dbg_val;

  int       checks = 0;
  int       errors = 0;
  int       cycles = 0;
  int       sent = 0;
  int       replies_done = 0;
  int       dbg_done = 0;
  bit       backpressure = 1'b0;
  word_t    cmd_words [16];
  word_t    stored [CMD_WORDS];
  reply_t   exp_q [$];
  reply_t   got;
  int       rpl_cnt = 0;
  logic     hold_pending = 1'b0;
  logic     cmd_in_flight = 1'b0;
  stream_beat_t hold_beat;
  logic [1:0]   rd_pipe = 2'b00;
  reg_addr_t    addr_pipe [2];

  secp256k1_verify_top uut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_cmd_beat (i_cmd_beat),
    .i_cmd_val  (i_cmd_val),
    .o_cmd_rdy  (o_cmd_rdy),
    .o_rpl_beat (o_rpl_beat),
    .o_rpl_val  (o_rpl_val),
    .i_rpl_rdy  (i_rpl_rdy),
    .i_dbg_rd   (i_dbg_rd),
    .i_dbg_addr (i_dbg_addr),
    .o_dbg_dat  (o_dbg_dat),
    .o_dbg_val  (o_dbg_val)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic scalar_t mul_mod(input scalar_t a, input scalar_t b);
    logic [511:0] p;
    p = {256'b0, a} * {256'b0, b};
    p = p % {256'b0, CURVE_N};
    return p[255:0];
  endfunction

  // Fermat inverse, s to the power n-2
  function automatic scalar_t inv_mod(input scalar_t s);
    scalar_t e;
    scalar_t acc;
    scalar_t base;
    int      i;
    e    = CURVE_N - 256'd2;
    acc  = 256'd1;
    base = s;
    for (i = 0; i < 256; i++) begin
      if (e[i]) begin
        acc = mul_mod(acc, base);
      end
      base = mul_mod(base, base);
    end
    return acc;
  endfunction

  function automatic reply_t ref_verify(input word_t hdr, input word_t index,
                                        input scalar_t s, input scalar_t r,
                                        input scalar_t hash);
    reply_t     rp;
    ver_flags_t fl;
    scalar_t    w;
    fl                = '0;
    fl.out_of_range_s = (s == '0) || (s >= CURVE_N);
    fl.out_of_range_r = (r == '0) || (r >= CURVE_N);
    rp.header         = hdr;
    rp.header[39:32]  = fl;
    rp.index          = index;
    rp.u1             = '0;
    rp.u2             = '0;
    if (!fl.out_of_range_s) begin
      w     = inv_mod(s);
      rp.u1 = mul_mod(hash, w);
      rp.u2 = mul_mod(r, w);
    end
    return rp;
  endfunction

  function automatic scalar_t random_scalar();
    scalar_t v;
    int      k;
    for (k = 0; k < 8; k++) begin
      v[k*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  function automatic scalar_t random_below_n();
    scalar_t v;
    v = random_scalar();
    while (v == '0 || v >= CURVE_N) begin
      v = random_scalar();
    end
    return v;
  endfunction

  task automatic check_word(input string name, input word_t got_v, input word_t exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED %s got=%h exp=%h", name, got_v, exp_v);
    end
  endtask

  task automatic check_scalar(input string name, input scalar_t got_v, input scalar_t exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED %s got=%h exp=%h", name, got_v, exp_v);
    end
  endtask

  task automatic check_flags(input string name, input ver_flags_t got_v,
                             input ver_flags_t exp_v);
    checks++;
    if (got_v !== exp_v) begin
      errors++;
      $display("CHECK FAILED %s got=%h exp=%h", name, got_v, exp_v);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("ERROR at cycle %0d: %s", cycles, msg);
  endtask

  // Sends cmd_words[0..len-1] with random gaps in val
  task automatic send_command(input int len);
    int   idx;
    logic acc;
    idx = 0;
    while (idx < len) begin
      @(posedge i_clk);
      acc = i_cmd_val && o_cmd_rdy;
      if (acc) begin
        idx = idx + 1;
      end
      if (acc || !i_cmd_val) begin
        if (idx < len && ($urandom % 4 != 0)) begin
          i_cmd_beat.dat <= cmd_words[idx];
          i_cmd_beat.sop <= (idx == 0);
          i_cmd_beat.eop <= (idx == len - 1);
          i_cmd_val      <= 1'b1;
        end else begin
          i_cmd_val <= 1'b0;
        end
      end
    end
  endtask

  task automatic wait_replies(input int n);
    while (replies_done < n) begin
      @(posedge i_clk);
    end
  endtask

  task automatic run_verify(input scalar_t s, input scalar_t r, input scalar_t hash);
    cmd_header_t hdr;
    word_t       index;
    int          k;
    hdr.code     = `SECP_CMD_VERIFY;
    hdr.tag      = 16'($urandom);
    hdr.rsvd     = $urandom;
    index        = {$urandom, $urandom};
    cmd_words[0] = hdr;
    cmd_words[1] = index;
    for (k = 0; k < 4; k++) begin
      cmd_words[2 + k]  = s[k*64 +: 64];
      cmd_words[6 + k]  = r[k*64 +: 64];
      cmd_words[10 + k] = hash[k*64 +: 64];
    end
    for (k = 0; k < CMD_WORDS; k++) begin
      stored[k] = cmd_words[k];
    end
    exp_q.push_back(ref_verify(hdr, index, s, r, hash));
    sent++;
    send_command(CMD_WORDS);
    cmd_in_flight <= 1'b1;
    wait_replies(sent);
  endtask

  task automatic run_unknown(input int len);
    cmd_header_t hdr;
    int          k;
    hdr.code     = 16'h0305;
    hdr.tag      = 16'($urandom);
    hdr.rsvd     = $urandom;
    cmd_words[0] = hdr;
    for (k = 1; k < len; k++) begin
      cmd_words[k] = {$urandom, $urandom};
    end
    send_command(len);
  endtask

  // Reads addresses 0 to 13, back to back or with random gaps
  task automatic debug_reads(input bit gapped);
    int a;
    int target;
    a      = 0;
    target = dbg_done + CMD_WORDS;
    while (a < CMD_WORDS) begin
      @(posedge i_clk);
      if (!gapped || ($urandom % 2 == 0)) begin
        i_dbg_rd   <= 1'b1;
        i_dbg_addr <= reg_addr_t'(a);
        a = a + 1;
      end else begin
        i_dbg_rd <= 1'b0;
      end
    end
    @(posedge i_clk);
    i_dbg_rd <= 1'b0;
    while (dbg_done < target) begin
      @(posedge i_clk);
    end
  endtask

  always @(posedge i_clk) begin
    i_rpl_rdy <= backpressure ? ($urandom % 3 != 0) : 1'b1;
  end

  // Reply collector and compare
  always @(posedge i_clk) begin
    if (!i_rst) begin
      if (hold_pending && (!o_rpl_val || o_rpl_beat !== hold_beat)) begin
        report_failure("reply beat changed or dropped while stalled");
      end
      hold_pending = o_rpl_val && !i_rpl_rdy;
      hold_beat    = o_rpl_beat;
      if (o_rpl_val && i_rpl_rdy) begin
        if (o_rpl_beat.sop !== (rpl_cnt == 0)) begin
          report_failure($sformatf("sop wrong on reply word %0d", rpl_cnt));
        end
        if (o_rpl_beat.eop !== (rpl_cnt == `SECP_RPL_WORDS - 1)) begin
          report_failure($sformatf("eop wrong on reply word %0d", rpl_cnt));
        end
        got[rpl_cnt*64 +: 64] = o_rpl_beat.dat;
        if (rpl_cnt == `SECP_RPL_WORDS - 1) begin
          rpl_cnt = 0;
          replies_done  <= replies_done + 1;
          cmd_in_flight <= 1'b0;
          if (exp_q.size() == 0) begin
            report_failure("reply received with no command pending");
          end else begin
            compare_reply(got, exp_q.pop_front());
          end
        end else begin
          rpl_cnt = rpl_cnt + 1;
        end
      end
    end
  end

  // Only one command in flight, the sender stays held off until its reply has left
  always @(posedge i_clk) begin
    if (cmd_in_flight && o_cmd_rdy) begin
      report_failure("command ready high while a reply is still pending");
    end
  end

  task automatic compare_reply(input reply_t got_r, input reply_t exp_r);
    check_word("reply header", got_r.header & ~FLAG_MASK, exp_r.header & ~FLAG_MASK);
    check_flags("reply flags", ver_flags_t'(got_r.header[39:32]),
                ver_flags_t'(exp_r.header[39:32]));
    check_word("reply index", got_r.index, exp_r.index);
    check_scalar("reply u1", got_r.u1, exp_r.u1);
    check_scalar("reply u2", got_r.u2, exp_r.u2);
  endtask

  // Debug read monitor, valid expected exactly two cycles after each read
  always @(posedge i_clk) begin
    if (o_dbg_val !== rd_pipe[1]) begin
      report_failure(rd_pipe[1] ? "debug read valid missing two cycles after the read"
                                : "debug read valid without a read two cycles before");
    end else if (rd_pipe[1]) begin
      check_word("o_dbg_dat", o_dbg_dat, stored[addr_pipe[1]]);
      dbg_done <= dbg_done + 1;
    end
    rd_pipe[1]   <= rd_pipe[0];
    rd_pipe[0]   <= i_dbg_rd;
    addr_pipe[1] <= addr_pipe[0];
    addr_pipe[0] <= i_dbg_addr;
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d replies seen",
               cycles, replies_done, sent);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Something failed");
      $finish;
    end
  end

  initial begin
    int k;
    void'($urandom(32'h8ea5_9855));
    i_rst      = 1'b1;
    i_cmd_beat = '0;
    i_cmd_val  = 1'b0;
    i_rpl_rdy  = 1'b0;
    i_dbg_rd   = 1'b0;
    i_dbg_addr = '0;
    repeat (2) @(posedge i_clk);
    i_rst <= 1'b0;

    // First command with the reply sink always ready, then debug readback
    run_verify(random_below_n(), random_below_n(), random_below_n());
    debug_reads(1'b0);
    debug_reads(1'b1);

    backpressure = 1'b1;
    for (k = 0; k < 6; k++) begin
      run_verify(random_below_n(), random_below_n(), random_below_n());
    end

    // s out of range
    run_verify('0, random_below_n(), random_below_n());
    run_verify(CURVE_N, random_below_n(), random_below_n());
    run_verify({256{1'b1}}, random_below_n(), random_below_n());

    // r out of range, u1 and u2 still computed
    run_verify(random_below_n(), CURVE_N, random_below_n());
    run_verify(random_below_n(), {256{1'b1}}, random_below_n());

    // Unknown commands are dropped and leave the register file alone
    run_unknown(5);
    run_unknown(1);
    repeat (50) @(posedge i_clk);
    if (replies_done != sent) begin
      report_failure("unknown command produced a reply");
    end
    debug_reads(1'b1);
    run_verify(random_below_n(), random_below_n(), random_below_n());
    debug_reads(1'b0);

    repeat (10) @(posedge i_clk);
    if (exp_q.size() != 0) begin
      report_failure("expected replies still pending at the end of the run");
    end
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+include
rtl/secp_field_pkg.sv
rtl/secp_cmd_pkg.sv
rtl/cmd_parser.sv
rtl/sig_register_file.sv
rtl/mod_inverse.sv
rtl/mod_mult.sv
rtl/verify_engine.sv
rtl/reply_builder.sv
rtl/secp256k1_verify_top.sv
verif/tb_secp256k1_verify.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  -f vlog.f --top-module tb_secp256k1_verify -o tb_sim

out=$(./obj_dir/tb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation did not pass"
  exit 1
fi
